// ==== source/comm_pkg.sv ====
// FIFO side types
package comm_pkg;

    // ----------------------------------------
    // basic fields
    // ----------------------------------------
    typedef logic [7:0]  byte_t;       // one FIFO data byte
    typedef logic [31:0] ip_t;
    typedef logic [47:0] mac_t;
    typedef logic [15:0] frame_len_t;  // byte count of a frame

    // sender or destination of a frame
    typedef struct packed {
        ip_t  ip;
        mac_t mac;
    } peer_t;

    // status word of both the RX and the TX FIFO, length on top
    typedef struct packed {
        frame_len_t length;
        ip_t        ip;
        mac_t       mac;
    } fifo_status_t;

    // ----------------------------------------
    // legal frame lengths
    // ----------------------------------------
    localparam frame_len_t CMD_ONLY_BYTES = 16'd4;  // command word only
    localparam frame_len_t CMD_DATA_BYTES = 16'd8;  // command plus 4 data bytes

endpackage

// ==== source/cmd_pkg.sv ====
// Command and reply definitions
package cmd_pkg;

    // ----------------------------------------
    // commands, four ASCII characters each
    // ----------------------------------------
    typedef enum logic [31:0] {
        CMD_VER  = 32'h5645_523F,  // VER?
        CMD_CONN = 32'h434F_4E4E,  // CONN
        CMD_COON = 32'h434F_4F4E,  // COON
        CMD_COFF = 32'h434F_4646,  // COFF
        CMD_RUN  = 32'h5255_4E3F,  // RUN?
        CMD_WIPE = 32'h5749_5045   // WIPE
    } cmd_code_t;

    // command word as seen by the evaluator
    typedef struct packed {
        logic [31:0] command;
        logic        length_ok;  // frame was 4 or 8 bytes
    } cmd_frame_t;

    typedef enum logic [2:0] {
        REPLY_ACK,
        REPLY_NAK,
        REPLY_ERR,
        REPLY_VER
    } reply_kind_t;

    // ----------------------------------------
    // reply text, first character on top
    // ----------------------------------------
    localparam int MAX_REPLY_BYTES = 8;

    typedef logic [$clog2(MAX_REPLY_BYTES + 1)-1:0] reply_len_t;

    localparam logic [7:0] CR = 8'h0D;
    localparam logic [7:0] LF = 8'h0A;

    localparam reply_len_t SHORT_REPLY_BYTES = 5;  // ACK, NAK, ERR
    localparam reply_len_t VERSION_BYTES     = 8;

    localparam logic [8*MAX_REPLY_BYTES-1:0] ACK_TEXT     = {"ACK", CR, LF, 24'h0};
    localparam logic [8*MAX_REPLY_BYTES-1:0] NAK_TEXT     = {"NAK", CR, LF, 24'h0};
    localparam logic [8*MAX_REPLY_BYTES-1:0] ERR_TEXT     = {"ERR", CR, LF, 24'h0};
    localparam logic [8*MAX_REPLY_BYTES-1:0] VERSION_TEXT = {"1.0TWE", CR, LF};

endpackage

// ==== source/rx_frame_reader.sv ====
// RX frame reader
`timescale 1ns/1ps

module rx_frame_reader (
    input  logic                   clk,
    input  logic                   reset,
    input  comm_pkg::byte_t        rx_fifo_data,
    input  comm_pkg::fifo_status_t rx_fifo_status,
    input  logic                   rx_fifo_status_empty,
    input  logic                   reply_busy,
    output logic                   rx_fifo_status_read,
    output logic                   rx_fifo_data_read,
    output logic                   frame_valid,
    output cmd_pkg::cmd_frame_t    frame,
    output comm_pkg::peer_t        peer
);
    import comm_pkg::*;
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_READ,
        RD_FLUSH,
        RD_DONE
    } rd_state_t;

    rd_state_t                  state;
    frame_len_t                 bytes_left;
    logic                       length_ok;
    logic                       with_data;
    logic                       frame_legal;
    logic                       start_frame;
    byte_t [CMD_DATA_BYTES-1:0] shift_reg;   // first byte ends up on top

    assign frame_legal = (rx_fifo_status.length == CMD_ONLY_BYTES) ||
                         (rx_fifo_status.length == CMD_DATA_BYTES);
    assign start_frame = (state == RD_IDLE) && !reply_busy && !rx_fifo_status_empty;

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state               <= RD_IDLE;
            rx_fifo_status_read <= 1'b0;
            rx_fifo_data_read   <= 1'b0;
            frame_valid         <= 1'b0;
            bytes_left          <= '0;
            length_ok           <= 1'b0;
            with_data           <= 1'b0;
        end
        else
        begin
            rx_fifo_status_read <= 1'b0;
            frame_valid         <= 1'b0;
            case (state)
                RD_IDLE:
                begin
                    if (start_frame)
                    begin
                        rx_fifo_status_read <= 1'b1;  // pop status word
                        bytes_left          <= rx_fifo_status.length;
                        length_ok           <= frame_legal;
                        with_data           <= (rx_fifo_status.length == CMD_DATA_BYTES);
                        state               <= frame_legal ? RD_READ : RD_FLUSH;
                    end
                end
                RD_READ, RD_FLUSH:
                begin
                    if (bytes_left != '0)
                    begin
                        rx_fifo_data_read <= 1'b1;
                        bytes_left        <= bytes_left - 1'b1;
                    end
                    else
                    begin
                        rx_fifo_data_read <= 1'b0;
                        frame_valid       <= 1'b1;  // last byte taken
                        state             <= RD_DONE;
                    end
                end
                RD_DONE:
                begin
                    if (reply_busy)  // writer owns the link until its reply is out
                        state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // sender and byte capture
    always_ff @(posedge clk)
    begin
        if (start_frame)
            peer <= '{ip: rx_fifo_status.ip, mac: rx_fifo_status.mac};
        if (rx_fifo_data_read && state == RD_READ)
            shift_reg <= {shift_reg[CMD_DATA_BYTES-2:0], rx_fifo_data};
    end

    assign frame = '{
        command:   with_data ? shift_reg[CMD_DATA_BYTES-1 -: CMD_ONLY_BYTES]
                             : shift_reg[CMD_ONLY_BYTES-1:0],
        length_ok: length_ok
    };

    assert property (@(posedge clk) disable iff (reset)
        !(rx_fifo_status_read && rx_fifo_data_read));

endmodule

// ==== source/cmd_evaluator.sv ====
// Command evaluator
`timescale 1ns/1ps

module cmd_evaluator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_valid,
    input  cmd_pkg::cmd_frame_t  frame,
    input  logic                 dac_running,
    input  logic                 dac_stopped,
    input  logic                 adc_ready,
    output logic                 reply_valid,
    output cmd_pkg::reply_kind_t reply_kind,
    output logic                 start_control_cmd,
    output logic                 stop_control_cmd,
    output logic                 wipe_settings
);
    import cmd_pkg::*;

    reply_kind_t kind_next;
    logic        start_next;
    logic        stop_next;
    logic        wipe_next;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_comb
    begin
        kind_next  = REPLY_NAK;  // bad length or unknown code
        start_next = 1'b0;
        stop_next  = 1'b0;
        wipe_next  = 1'b0;
        if (frame.length_ok)
        begin
            case (frame.command)
                CMD_VER:  kind_next = REPLY_VER;
                CMD_CONN: kind_next = REPLY_ACK;  // keepalive
                CMD_COON:
                begin
                    start_next = dac_stopped && adc_ready;
                    kind_next  = start_next ? REPLY_ACK : REPLY_ERR;
                end
                CMD_COFF:
                begin
                    stop_next = dac_running;
                    kind_next = stop_next ? REPLY_ACK : REPLY_ERR;
                end
                CMD_RUN:  kind_next = dac_running ? REPLY_ACK : REPLY_ERR;
                CMD_WIPE:
                begin
                    wipe_next = dac_stopped;  // only wipe with the DAC idle
                    kind_next = wipe_next ? REPLY_ACK : REPLY_ERR;
                end
                default:  kind_next = REPLY_NAK;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reply_valid       <= 1'b0;
            start_control_cmd <= 1'b0;
            stop_control_cmd  <= 1'b0;
            wipe_settings     <= 1'b0;
        end
        else
        begin
            reply_valid       <= frame_valid;
            start_control_cmd <= frame_valid && start_next;
            stop_control_cmd  <= frame_valid && stop_next;
            wipe_settings     <= frame_valid && wipe_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_valid)
            reply_kind <= kind_next;
    end

    assert property (@(posedge clk) disable iff (reset)
        $onehot0({start_control_cmd, stop_control_cmd, wipe_settings}));

    assert property (@(posedge clk) disable iff (reset)
        (start_control_cmd || stop_control_cmd || wipe_settings) |-> reply_valid);

endmodule

// ==== source/reply_writer.sv ====
// Reply writer
`timescale 1ns/1ps

module reply_writer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   reply_valid,
    input  cmd_pkg::reply_kind_t   reply_kind,
    input  comm_pkg::peer_t        peer,
    input  logic                   tx_fifo_data_full,
    output comm_pkg::byte_t        tx_fifo_data,
    output logic                   tx_fifo_data_write,
    output comm_pkg::fifo_status_t tx_fifo_status,
    output logic                   tx_fifo_status_write,
    output logic                   reply_busy
);
    import comm_pkg::*;
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WRITE,
        WR_STATUS
    } wr_state_t;

    wr_state_t                   state;
    byte_t [MAX_REPLY_BYTES-1:0] text_next;
    reply_len_t                  len_next;
    byte_t [MAX_REPLY_BYTES-1:0] reply_buf;   // next byte on top
    reply_len_t                  reply_len;
    reply_len_t                  bytes_left;
    peer_t                       dest;
    logic                        load_reply;
    logic                        send_byte;
    logic                        send_status;

    always_comb
    begin
        case (reply_kind)
            REPLY_ACK: text_next = ACK_TEXT;
            REPLY_ERR: text_next = ERR_TEXT;
            REPLY_VER: text_next = VERSION_TEXT;
            default:   text_next = NAK_TEXT;
        endcase
    end

    assign len_next    = (reply_kind == REPLY_VER) ? VERSION_BYTES : SHORT_REPLY_BYTES;
    assign load_reply  = (state == WR_IDLE) && reply_valid;
    assign send_byte   = (state == WR_WRITE) && (bytes_left != '0) && !tx_fifo_data_full;
    assign send_status = (state == WR_WRITE) && (bytes_left == '0);

    // ----------------------------------------
    // write FSM
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state                <= WR_IDLE;
            tx_fifo_data_write   <= 1'b0;
            tx_fifo_status_write <= 1'b0;
            reply_busy           <= 1'b0;
            bytes_left           <= '0;
        end
        else
        begin
            tx_fifo_data_write   <= send_byte;
            tx_fifo_status_write <= send_status;
            case (state)
                WR_IDLE:
                begin
                    if (load_reply)
                    begin
                        reply_busy <= 1'b1;
                        bytes_left <= len_next;
                        state      <= WR_WRITE;
                    end
                end
                WR_WRITE:
                begin
                    if (send_status)
                        state <= WR_STATUS;
                    else if (send_byte)
                        bytes_left <= bytes_left - 1'b1;  // full holds our place
                end
                WR_STATUS:
                begin
                    reply_busy <= 1'b0;  // status word is going out now
                    state      <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // reply text and address
    always_ff @(posedge clk)
    begin
        if (load_reply)
        begin
            reply_buf <= text_next;
            reply_len <= len_next;
            dest      <= peer;  // answer goes to the last sender
        end
        else if (send_byte)
        begin
            tx_fifo_data <= reply_buf[MAX_REPLY_BYTES-1];
            reply_buf    <= {reply_buf[MAX_REPLY_BYTES-2:0], 8'h00};
        end
        if (send_status)
            tx_fifo_status <= '{length: frame_len_t'(reply_len), ip: dest.ip, mac: dest.mac};
    end

    // the reader holds off new frames while a reply is out
    assert property (@(posedge clk) disable iff (reset) reply_valid |-> state == WR_IDLE);

    assert property (@(posedge clk) disable iff (reset)
        !(tx_fifo_data_write && tx_fifo_status_write));

    assert property (@(posedge clk) disable iff (reset)
        tx_fifo_data_full |=> !tx_fifo_data_write);

endmodule

// ==== source/cmd_decoder_top.sv ====
// Ethernet command decoder
`timescale 1ns/1ps

module cmd_decoder_top (
    input  logic                   clk,
    input  logic                   reset,
    input  comm_pkg::byte_t        rx_fifo_data,
    input  comm_pkg::fifo_status_t rx_fifo_status,
    input  logic                   rx_fifo_status_empty,
    input  logic                   tx_fifo_data_full,
    input  logic                   dac_running,
    input  logic                   dac_stopped,
    input  logic                   adc_ready,
    output logic                   rx_fifo_status_read,
    output logic                   rx_fifo_data_read,
    output comm_pkg::byte_t        tx_fifo_data,
    output logic                   tx_fifo_data_write,
    output comm_pkg::fifo_status_t tx_fifo_status,
    output logic                   tx_fifo_status_write,
    output logic                   start_control_cmd,
    output logic                   stop_control_cmd,
    output logic                   wipe_settings
);
    import comm_pkg::*;
    import cmd_pkg::*;

    logic        frame_valid;
    cmd_frame_t  frame;
    peer_t       peer;
    logic        reply_valid;
    reply_kind_t reply_kind;
    logic        reply_busy;    // holds the reader off until the reply is sent

    // ----------------------------------------
    // RX -> evaluate -> TX
    // ----------------------------------------
    rx_frame_reader u_rx_frame_reader (
        .clk                  (clk),
        .reset                (reset),
        .rx_fifo_data         (rx_fifo_data),
        .rx_fifo_status       (rx_fifo_status),
        .rx_fifo_status_empty (rx_fifo_status_empty),
        .reply_busy           (reply_busy),
        .rx_fifo_status_read  (rx_fifo_status_read),
        .rx_fifo_data_read    (rx_fifo_data_read),
        .frame_valid          (frame_valid),
        .frame                (frame),
        .peer                 (peer)
    );

    cmd_evaluator u_cmd_evaluator (
        .clk               (clk),
        .reset             (reset),
        .frame_valid       (frame_valid),
        .frame             (frame),
        .dac_running       (dac_running),
        .dac_stopped       (dac_stopped),
        .adc_ready         (adc_ready),
        .reply_valid       (reply_valid),
        .reply_kind        (reply_kind),
        .start_control_cmd (start_control_cmd),
        .stop_control_cmd  (stop_control_cmd),
        .wipe_settings     (wipe_settings)
    );

    reply_writer u_reply_writer (
        .clk                  (clk),
        .reset                (reset),
        .reply_valid          (reply_valid),
        .reply_kind           (reply_kind),
        .peer                 (peer),
        .tx_fifo_data_full    (tx_fifo_data_full),
        .tx_fifo_data         (tx_fifo_data),
        .tx_fifo_data_write   (tx_fifo_data_write),
        .tx_fifo_status       (tx_fifo_status),
        .tx_fifo_status_write (tx_fifo_status_write),
        .reply_busy           (reply_busy)
    );

endmodule

// ==== verification/cmd_decoder_tb.sv ====
// Command decoder testbench
`timescale 1ns/1ps

module cmd_decoder_tb;
    import comm_pkg::*;

    localparam int CYCLES_PER_TEST = 300;

    typedef enum logic [1:0] {PULSE_NONE, PULSE_START, PULSE_STOP, PULSE_WIPE} pulse_t;

    typedef struct packed {
        logic [3:0] start;
        logic [3:0] stop;
        logic [3:0] wipe;
    } pulse_count_t;

    typedef struct packed {
        logic [63:0] text;  // first character on top
        logic [3:0]  len;
    } reply_t;

    typedef struct packed {
        logic [8*12-1:0] name;
        frame_len_t      length;
        logic [63:0]     data;    // first byte on top
        peer_t           sender;
        logic [2:0]      flags;   // dac_running, dac_stopped, adc_ready
        logic            burst;   // queued together with the other burst entries
        reply_t          reply;
        pulse_t          pulse;
    } test_t;

    typedef struct packed {
        fifo_status_t status;
        pulse_count_t pulses;     // pulses seen since the previous reply
        logic [7:0]   nbytes;
    } reply_rec_t;

    localparam reply_t R_ACK = {"ACK", 8'h0d, 8'h0a, 24'h0, 4'd5};
    localparam reply_t R_NAK = {"NAK", 8'h0d, 8'h0a, 24'h0, 4'd5};
    localparam reply_t R_ERR = {"ERR", 8'h0d, 8'h0a, 24'h0, 4'd5};
    localparam reply_t R_VER = {"1.0TWE", 8'h0d, 8'h0a, 4'd8};

    logic         clk = 1'b0;
    logic         reset;
    byte_t        rx_fifo_data;
    fifo_status_t rx_fifo_status;
    logic         rx_fifo_status_empty;
    logic         tx_fifo_data_full;
    logic         dac_running;
    logic         dac_stopped;
    logic         adc_ready;
    logic         rx_fifo_status_read;
    logic         rx_fifo_data_read;
    byte_t        tx_fifo_data;
    logic         tx_fifo_data_write;
    fifo_status_t tx_fifo_status;
    logic         tx_fifo_status_write;
    logic         start_control_cmd;
    logic         stop_control_cmd;
    logic         wipe_settings;

    test_t        tests[$];
    fifo_status_t status_q[$];    // RX status FIFO model
    byte_t        byte_q[$];      // RX data FIFO model
    byte_t        tx_byte_q[$];
    reply_rec_t   reply_q[$];
    logic         status_pop;
    logic         data_pop;
    logic [7:0]   bytes_seen;
    pulse_count_t pulse_acc;

    always #2 clk = ~clk;

    cmd_decoder_top u_cmd_decoder_top (.*);

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare(input logic [8*12-1:0] test_name, input string what,
                           input logic [95:0] expected, input logic [95:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch %0s %0s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            report_error("value does not match the expected value");
        end
    endtask

    // ----------------------------------------
    // FIFO models and TX capture
    // ----------------------------------------
    initial
    begin
        void'($urandom(32'hc938));  // back-pressure sequence
        forever
        begin
            @(negedge clk);
            // strobes seen at the last rising edge consume the heads now
            if (status_pop)
            begin
                if (status_q.size() == 0)
                    report_error("status word read from an empty RX FIFO");
                void'(status_q.pop_front());
            end
            if (data_pop)
            begin
                if (byte_q.size() == 0)
                    report_error("data byte read from an empty RX FIFO");
                void'(byte_q.pop_front());
            end
            status_pop = rx_fifo_status_read;
            data_pop   = rx_fifo_data_read;
            rx_fifo_status_empty = (status_q.size() == 0);
            rx_fifo_status       = (status_q.size() != 0) ? status_q[0] : '0;
            rx_fifo_data         = (byte_q.size() != 0) ? byte_q[0] : '0;

            if (tx_fifo_data_write)
            begin
                if (tx_fifo_data_full)
                    report_error("TX data written while the FIFO reported full");
                tx_byte_q.push_back(tx_fifo_data);
                bytes_seen = bytes_seen + 8'd1;
            end
            if (start_control_cmd)
                pulse_acc.start = pulse_acc.start + 4'd1;
            if (stop_control_cmd)
                pulse_acc.stop = pulse_acc.stop + 4'd1;
            if (wipe_settings)
                pulse_acc.wipe = pulse_acc.wipe + 4'd1;
            if (tx_fifo_status_write)
            begin
                reply_q.push_back({tx_fifo_status, pulse_acc, bytes_seen});
                bytes_seen = '0;
                pulse_acc  = '0;
            end
            tx_fifo_data_full = ($urandom % 3 == 0);  // random back-pressure
        end
    end

    task automatic add_test(input logic [8*12-1:0] name, input frame_len_t length,
                            input logic [63:0] data, input logic [7:0] host_id,
                            input logic [2:0] flags, input logic burst,
                            input reply_t reply, input pulse_t pulse);
        test_t t;
        t.name   = name;
        t.length = length;
        t.data   = data;
        t.sender = '{ip: {8'd10, 8'd0, 8'd7, host_id}, mac: {40'h02_00_5e_10_00, host_id}};
        t.flags  = flags;
        t.burst  = burst;
        t.reply  = reply;
        t.pulse  = pulse;
        tests.push_back(t);
    endtask

    task automatic build_table();
        add_test("ver",        4, {"VER?", 32'h0},        8'd1,  3'b000, 0, R_VER, PULSE_NONE);
        add_test("conn",       4, {"CONN", 32'h0},        8'd2,  3'b000, 0, R_ACK, PULSE_NONE);
        add_test("run_on",     4, {"RUN?", 32'h0},        8'd3,  3'b100, 0, R_ACK, PULSE_NONE);
        add_test("run_off",    4, {"RUN?", 32'h0},        8'd4,  3'b011, 0, R_ERR, PULSE_NONE);
        add_test("coon_ok",    4, {"COON", 32'h0},        8'd5,  3'b011, 0, R_ACK, PULSE_START);
        add_test("coon_noadc", 4, {"COON", 32'h0},        8'd6,  3'b010, 0, R_ERR, PULSE_NONE);
        add_test("coon_busy",  4, {"COON", 32'h0},        8'd7,  3'b101, 0, R_ERR, PULSE_NONE);
        add_test("coff_ok",    4, {"COFF", 32'h0},        8'd8,  3'b100, 0, R_ACK, PULSE_STOP);
        add_test("coff_idle",  4, {"COFF", 32'h0},        8'd9,  3'b011, 0, R_ERR, PULSE_NONE);
        add_test("wipe_ok",    4, {"WIPE", 32'h0},        8'd10, 3'b010, 0, R_ACK, PULSE_WIPE);
        add_test("wipe_busy",  4, {"WIPE", 32'h0},        8'd11, 3'b100, 0, R_ERR, PULSE_NONE);
        add_test("coff_data",  8, {"COFF", 32'hdead_beef}, 8'd12, 3'b100, 0, R_ACK, PULSE_STOP);
        add_test("ver_data",   8, {"VER?", "WIPE"},       8'd13, 3'b000, 0, R_VER, PULSE_NONE);
        add_test("len5",       5, {"CONN!", 24'h0},       8'd14, 3'b000, 0, R_NAK, PULSE_NONE);
        add_test("len1",       1, {"W", 56'h0},           8'd15, 3'b000, 0, R_NAK, PULSE_NONE);
        add_test("unknown",    4, {"HELO", 32'h0},        8'd16, 3'b011, 0, R_NAK, PULSE_NONE);
        add_test("unknown8",   8, {"ABCD", "CONN"},       8'd17, 3'b011, 0, R_NAK, PULSE_NONE);
        // back-to-back group, all with the DAC stopped and the ADC ready
        add_test("b_conn",     4, {"CONN", 32'h0},        8'd20, 3'b011, 1, R_ACK, PULSE_NONE);
        add_test("b_len6",     6, {"WIPE", 16'h1234, 16'h0}, 8'd21, 3'b011, 1, R_NAK, PULSE_NONE);
        add_test("b_wipe",     4, {"WIPE", 32'h0},        8'd22, 3'b011, 1, R_ACK, PULSE_WIPE);
        add_test("b_ver8",     8, {"VER?", 32'h0102_0304}, 8'd23, 3'b011, 1, R_VER, PULSE_NONE);
        add_test("b_coon",     4, {"COON", 32'h0},        8'd24, 3'b011, 1, R_ACK, PULSE_START);
    endtask

    function automatic pulse_count_t pulses_for(input pulse_t pulse);
        pulse_count_t c;
        c = '0;
        case (pulse)
            PULSE_START: c.start = 4'd1;
            PULSE_STOP:  c.stop  = 4'd1;
            PULSE_WIPE:  c.wipe  = 4'd1;
            default:     c = '0;
        endcase
        return c;
    endfunction

    task automatic push_frame(input test_t t);
        int j;
        status_q.push_back(fifo_status_t'{length: t.length, ip: t.sender.ip,
                                          mac: t.sender.mac});
        for (j = 0; j < int'(t.length); j++)
            byte_q.push_back(t.data[63 - 8*j -: 8]);
    endtask

    task automatic wait_replies(input int n);
        while (reply_q.size() < n)
            @(posedge clk);
    endtask

    task automatic check_reply(input test_t t);
        reply_rec_t r;
        byte_t      b;
        int         j;
        r = reply_q.pop_front();
        compare(t.name, "reply length", 96'(t.reply.len), 96'(r.nbytes));
        for (j = 0; j < int'(r.nbytes); j++)
        begin
            b = tx_byte_q.pop_front();
            compare(t.name, $sformatf("reply byte %0d", j), 96'(t.reply.text[63 - 8*j -: 8]),
                    96'(b));
        end
        compare(t.name, "status length", 96'(t.reply.len), 96'(r.status.length));
        compare(t.name, "status ip", 96'(t.sender.ip), 96'(r.status.ip));
        compare(t.name, "status mac", 96'(t.sender.mac), 96'(r.status.mac));
        compare(t.name, "pulses", 96'(pulses_for(t.pulse)), 96'(r.pulses));
    endtask

    task automatic watchdog();
        repeat (tests.size() * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: %0d tests did not finish within %0d cycles each",
                 tests.size(), CYCLES_PER_TEST);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial
    begin
        int i;
        int n_burst;
        reset                = 1'b1;
        rx_fifo_data         = '0;
        rx_fifo_status       = '0;
        rx_fifo_status_empty = 1'b1;
        tx_fifo_data_full    = 1'b0;
        {dac_running, dac_stopped, adc_ready} = 3'b000;
        status_pop = 1'b0;
        data_pop   = 1'b0;
        bytes_seen = '0;
        pulse_acc  = '0;
        build_table();
        fork
            watchdog();
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (i = 0; i < tests.size(); i++)
        begin
            if (!tests[i].burst)
            begin
                @(negedge clk);
                {dac_running, dac_stopped, adc_ready} = tests[i].flags;
                @(posedge clk);
                push_frame(tests[i]);
                wait_replies(1);
                check_reply(tests[i]);
                compare(tests[i].name, "rx bytes left", 96'd0, 96'(byte_q.size()));
            end
        end

        // queue the whole group at once, replies must come back in order
        n_burst = 0;
        @(negedge clk);
        {dac_running, dac_stopped, adc_ready} = 3'b011;
        @(posedge clk);
        for (i = 0; i < tests.size(); i++)
        begin
            if (tests[i].burst)
            begin
                push_frame(tests[i]);
                n_burst++;
            end
        end
        wait_replies(n_burst);
        for (i = 0; i < tests.size(); i++)
        begin
            if (tests[i].burst)
                check_reply(tests[i]);
        end
        compare("burst", "rx bytes left", 96'd0, 96'(byte_q.size()));

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/comm_pkg.sv
source/cmd_pkg.sv
source/rx_frame_reader.sv
source/cmd_evaluator.sv
source/reply_writer.sv
source/cmd_decoder_top.sv
verification/cmd_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the command decoder simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module cmd_decoder_tb -o cmd_decoder_sim

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/cmd_decoder_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** FAILED ***" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
exit 0
